//--- spi_ctrl.f
design/spi_pkg.sv
design/spi_fifo.sv
design/spi_shift_engine.sv
design/spi_reg_file.sv
design/spi_ctrl.sv
testbench/spi_slave_model.sv
testbench/spi_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= spi_ctrl_tb
RTL_TOP   ?= spi_ctrl
FILELIST  ?= spi_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "simulation did not finish"; exit 1)

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) \
		design/spi_pkg.sv design/spi_fifo.sv design/spi_shift_engine.sv \
		design/spi_reg_file.sv design/spi_ctrl.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/spi_ctrl_tb.sv
// testbench for the spi master controller.
// drives the register port, talks to a behavioral slave and checks every byte.

module spi_ctrl_tb;
    import spi_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        reg_wr_en;
    logic        reg_rd_en;
    reg_addr_t   reg_addr;
    reg_data_t   reg_wdata;
    reg_data_t   reg_rdata;
    logic        sclk;
    logic        mosi;
    logic        miso;
    logic [1:0]  cs_n;
    logic        cpol_r;
    logic        cpha_r;
    int unsigned slave_cnt;

    logic [7:0]  sent_q[$];     // bytes the slave should see, in order.
    int unsigned rx_idx;
    logic [1:0]  cs_prev = 2'b11;
    int unsigned cs0_falls = 0;
    int unsigned cs1_falls = 0;

    spi_ctrl spi_ctrl_i (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .reg_wr_en_i(reg_wr_en),
        .reg_rd_en_i(reg_rd_en),
        .reg_addr_i (reg_addr),
        .reg_wdata_i(reg_wdata),
        .reg_rdata_o(reg_rdata),
        .sclk_o     (sclk),
        .mosi_o     (mosi),
        .miso_i     (miso),
        .cs_n_o     (cs_n)
    );

    spi_slave_model slave_i (
        .rst_n_i(rst_n),
        .cpol_i (cpol_r),
        .cpha_i (cpha_r),
        .sclk_i (sclk),
        .mosi_i (mosi),
        .cs_n_i (cs_n),
        .miso_o (miso),
        .count_o(slave_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cs_prev <= cs_n;
        if (cs_prev[0] && !cs_n[0]) cs0_falls <= cs0_falls + 1;
        if (cs_prev[1] && !cs_n[1]) cs1_falls <= cs1_falls + 1;
    end

    // the slave answers byte n with the inverse of byte n-1.
    function automatic logic [7:0] expected_rx(input int unsigned idx);
        if (idx == 0) begin
            return 8'hA5;
        end
        return ~sent_q[idx-1];
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at time %0t: %s never happened", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        @(negedge clk);
        reg_wr_en = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr_en = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
        @(negedge clk);
        reg_rd_en = 1'b1;
        reg_addr  = addr;
        @(negedge clk);
        reg_rd_en = 1'b0;
        data      = reg_rdata;
    endtask

    task automatic wait_status(input int bit_idx, input logic value, input string what);
        reg_data_t   st;
        int unsigned tries;
        tries = 0;
        reg_read(REG_STATUS, st);
        while (st[bit_idx] !== value) begin
            tries++;
            if (tries > 20000) report_timeout(what);
            reg_read(REG_STATUS, st);
        end
    endtask

    task automatic set_mode(input logic pol, input logic pha, input logic stop);
        cpol_r = pol;
        cpha_r = pha;
        reg_write(REG_CONTROL, {28'd0, stop, pha, pol, 1'b0});
    endtask

    // waits for room in the TX FIFO, then pushes.
    task automatic push_tx(input logic [7:0] data);
        wait_status(1, 1'b0, "room in the TX FIFO");
        reg_write(REG_TX_DATA, {24'd0, data});
        sent_q.push_back(data);
    endtask

    task automatic drain_rx(input int unsigned n);
        reg_data_t data;
        repeat (n) begin
            wait_status(2, 1'b0, "a byte in the RX FIFO");
            reg_read(REG_RX_DATA, data);
            check_eq("RX_DATA", data, {24'd0, expected_rx(rx_idx)});
            check_eq("byte seen by slave", slave_i.got_mem[rx_idx], sent_q[rx_idx]);
            rx_idx++;
        end
    endtask

    initial begin
        reg_data_t   data;
        int unsigned accepted;
        int unsigned falls;
        logic        full_seen;

        void'($urandom(32'h2556));
        rst_n     = 1'b0;
        reg_wr_en = 1'b0;
        reg_rd_en = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        cpol_r    = 1'b0;
        cpha_r    = 1'b0;
        rx_idx    = 0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        reg_read(REG_STATUS, data);
        check_eq("STATUS after reset", data, 32'h0000_0005);
        reg_read(REG_PARAM, data);
        check_eq("PARAM", data, 32'h0800_1008);
        check_eq("cs_n after reset", cs_n, 2'b11);
        check_eq("sclk after reset", sclk, 1'b0);
        check_eq("mosi after reset", mosi, 1'b0);

        for (int mode = 0; mode < 4; mode++) begin
            reg_write(REG_CLK_DIV, $urandom_range(1, 6));
            set_mode(mode[1], mode[0], 1'b0);
            repeat (4) push_tx(8'($urandom));
            drain_rx(4);
            wait_status(4, 1'b0, "busy clear after a mode test");
            check_eq("sclk idle level", sclk, mode[1]);
        end

        // chip select framing on slave 1.
        set_mode(1'b0, 1'b0, 1'b1);
        reg_write(REG_SLAVE, 32'd1);
        falls = cs1_falls;
        accepted = cs0_falls;
        push_tx(8'($urandom));
        push_tx(8'($urandom));
        drain_rx(2);
        wait_status(4, 1'b0, "busy clear after stop framing");
        check_eq("cs1 frames with stop", cs1_falls - falls, 32'd2);
        set_mode(1'b0, 1'b0, 1'b0);
        falls = cs1_falls;
        repeat (3) push_tx(8'($urandom));
        drain_rx(3);
        wait_status(4, 1'b0, "busy clear after a burst");
        check_eq("cs1 frames in burst", cs1_falls - falls, 32'd1);
        check_eq("cs0 stays high", cs0_falls - accepted, 32'd0);
        reg_write(REG_SLAVE, 32'd0);

        // overfill TX; the engine holds one byte outside the FIFO.
        reg_write(REG_CLK_DIV, 32'd40);
        accepted  = 0;
        full_seen = 1'b0;
        repeat (20) begin
            reg_read(REG_STATUS, data);
            if (data[1]) begin
                full_seen = 1'b1;
            end else begin
                sent_q.push_back(8'($urandom));
                accepted++;
            end
            reg_write(REG_TX_DATA, {24'd0, data[1] ? 8'h00 : sent_q[$]});
        end
        check_eq("tx_full seen", full_seen, 1'b1);
        check_eq("bytes accepted", accepted, FIFO_DEPTH + 1);
        drain_rx(accepted);
        wait_status(4, 1'b0, "busy clear after overfill");
        check_eq("bytes sent to slave", slave_cnt, sent_q.size());

        // RX back-pressure.
        reg_write(REG_CLK_DIV, 32'd2);
        repeat (17) push_tx(8'($urandom));
        wait_status(3, 1'b1, "rx_full with the engine stalled");
        repeat (200) @(negedge clk);
        reg_read(REG_STATUS, data);
        check_eq("stalled busy and rx_full", {data[4], data[3]}, 2'b11);
        drain_rx(17);
        wait_status(4, 1'b0, "busy clear after back-pressure");

        // soft reset in the middle of a byte.
        reg_write(REG_CLK_DIV, 32'd20);
        reg_write(REG_TX_DATA, 32'h5A);
        reg_write(REG_TX_DATA, 32'h3C);
        reg_write(REG_TX_DATA, 32'hC3);
        wait_status(4, 1'b1, "busy set before soft reset");
        repeat (100) @(negedge clk);
        reg_write(REG_CONTROL, 32'h1);
        wait_status(4, 1'b0, "busy clear after soft reset");
        reg_read(REG_STATUS, data);
        check_eq("STATUS after soft reset", data, 32'h0000_0005);
        check_eq("cs_n after soft reset", cs_n, 2'b11);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- testbench/spi_slave_model.sv
// behavioral spi slave for the controller testbench.
// samples MOSI in any CPOL/CPHA mode and answers each byte with the inverse
// of the byte it received before, or 8'hA5 for the first byte after reset.

module spi_slave_model (
    input  logic        rst_n_i,
    input  logic        cpol_i,
    input  logic        cpha_i,
    input  logic        sclk_i,
    input  logic        mosi_i,
    input  logic [1:0]  cs_n_i,
    output logic        miso_o,
    output int unsigned count_o
);
    logic [7:0]  got_mem [128];     // every completed byte, in order.
    logic [7:0]  in_q = '0;
    logic [7:0]  out_q = 8'hA5;
    logic [7:0]  prev_q = '0;
    logic        first_q = 1'b1;
    int unsigned bit_cnt = 0;
    int unsigned cnt = 0;
    logic        cs_prev = 1'b0;
    logic        sclk_prev = 1'b0;
    logic        cs_low;
    logic        leading;

    assign cs_low  = ~&cs_n_i;
    assign miso_o  = out_q[7];
    assign count_o = cnt;

    always @(sclk_i or cs_low or rst_n_i) begin
        if (!rst_n_i) begin
            first_q = 1'b1;
            prev_q  = '0;
            bit_cnt = 0;
            cnt     = 0;
            out_q   = 8'hA5;
        end else if (cs_low != cs_prev) begin
            bit_cnt = 0;  // a frame cut short by chip select is dropped.
            if (cs_low) begin
                out_q = first_q ? 8'hA5 : ~prev_q;
            end
        end else if (cs_low && sclk_i != sclk_prev) begin
            leading = (sclk_i != cpol_i);
            if (leading ^ cpha_i) begin
                in_q    = {in_q[6:0], mosi_i};
                bit_cnt = bit_cnt + 1;
                if (bit_cnt == 8) begin
                    got_mem[cnt] = in_q;
                    cnt          = cnt + 1;
                    prev_q       = in_q;
                    first_q      = 1'b0;
                    bit_cnt      = 0;
                end
            end else if (bit_cnt == 0) begin
                out_q = first_q ? 8'hA5 : ~prev_q;
            end else begin
                out_q = {out_q[6:0], 1'b0};
            end
        end
        cs_prev   = cs_low;
        sclk_prev = sclk_i;
    end

endmodule

//--- design/spi_ctrl.sv
// spi master controller top level.
// ties the register file, the TX and RX FIFOs and the shift engine together.

module spi_ctrl (
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    input  logic                          reg_wr_en_i,
    input  logic                          reg_rd_en_i,
    input  spi_pkg::reg_addr_t            reg_addr_i,
    input  spi_pkg::reg_data_t            reg_wdata_i,
    output spi_pkg::reg_data_t            reg_rdata_o,

    output logic                          sclk_o,
    output logic                          mosi_o,
    input  logic                          miso_i,
    output logic [spi_pkg::SLAVE_NUM-1:0] cs_n_o
);
    import spi_pkg::*;

    spi_cfg_t    cfg;
    logic        clear;
    logic        busy;

    spi_data_t   tx_push_data;
    logic        tx_push_valid;
    logic        tx_push_ready;
    spi_data_t   tx_pop_data;
    logic        tx_pop_valid;
    logic        tx_pop_ready;

    spi_data_t   rx_push_data;
    logic        rx_push_valid;
    logic        rx_push_ready;
    spi_data_t   rx_pop_data;
    logic        rx_pop_valid;
    logic        rx_pop_ready;

    fifo_level_t tx_level;
    fifo_level_t rx_level;

    spi_reg_file u_reg_file (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .reg_wr_en_i(reg_wr_en_i),
        .reg_rd_en_i(reg_rd_en_i),
        .reg_addr_i (reg_addr_i),
        .reg_wdata_i(reg_wdata_i),
        .reg_rdata_o(reg_rdata_o),
        .cfg_o      (cfg),
        .clear_o    (clear),
        .tx_data_o  (tx_push_data),
        .tx_valid_o (tx_push_valid),
        .tx_ready_i (tx_push_ready),
        .rx_data_i  (rx_pop_data),
        .rx_valid_i (rx_pop_valid),
        .rx_ready_o (rx_pop_ready),
        .tx_level_i (tx_level),
        .rx_level_i (rx_level),
        .busy_i     (busy)
    );

    spi_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) u_tx_fifo (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .clear_i    (clear),
        .in_data_i  (tx_push_data),
        .in_valid_i (tx_push_valid),
        .in_ready_o (tx_push_ready),
        .out_data_o (tx_pop_data),
        .out_valid_o(tx_pop_valid),
        .out_ready_i(tx_pop_ready),
        .level_o    (tx_level)
    );

    spi_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) u_rx_fifo (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .clear_i    (clear),
        .in_data_i  (rx_push_data),
        .in_valid_i (rx_push_valid),
        .in_ready_o (rx_push_ready),
        .out_data_o (rx_pop_data),
        .out_valid_o(rx_pop_valid),
        .out_ready_i(rx_pop_ready),
        .level_o    (rx_level)
    );

    spi_shift_engine u_shift_engine (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .clear_i   (clear),
        .cfg_i     (cfg),
        .tx_data_i (tx_pop_data),
        .tx_valid_i(tx_pop_valid),
        .tx_ready_o(tx_pop_ready),
        .rx_data_o (rx_push_data),
        .rx_valid_o(rx_push_valid),
        .rx_ready_i(rx_push_ready),
        .busy_o    (busy),
        .sclk_o    (sclk_o),
        .mosi_o    (mosi_o),
        .miso_i    (miso_i),
        .cs_n_o    (cs_n_o)
    );

endmodule

//--- design/spi_reg_file.sv
// register file of the spi controller.
// holds the configuration, feeds the TX FIFO, drains the RX FIFO and builds status.

module spi_reg_file (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic                 reg_wr_en_i,
    input  logic                 reg_rd_en_i,
    input  spi_pkg::reg_addr_t   reg_addr_i,
    input  spi_pkg::reg_data_t   reg_wdata_i,
    output spi_pkg::reg_data_t   reg_rdata_o,

    output spi_pkg::spi_cfg_t    cfg_o,
    output logic                 clear_o,

    output spi_pkg::spi_data_t   tx_data_o,
    output logic                 tx_valid_o,
    input  logic                 tx_ready_i,

    input  spi_pkg::spi_data_t   rx_data_i,
    input  logic                 rx_valid_i,
    output logic                 rx_ready_o,

    input  spi_pkg::fifo_level_t tx_level_i,
    input  spi_pkg::fifo_level_t rx_level_i,
    input  logic                 busy_i
);
    import spi_pkg::*;

    spi_cfg_t    cfg_q;
    logic        soft_rst_q;
    ctrl_reg_t   wr_ctrl;
    spi_status_t status;
    param_reg_t  param;
    reg_data_t   rdata_d;
    reg_data_t   rdata_q;
    logic        rx_pop_req;

    assign wr_ctrl = ctrl_reg_t'(reg_wdata_i);

    assign param = '{
        reg_num:    8'(REG_NUM),
        fifo_depth: 16'(FIFO_DEPTH),
        data_width: 8'(SPI_DATA_WIDTH)
    };

    always_comb begin
        status.tx_empty = (tx_level_i == '0);
        status.tx_full  = ~tx_ready_i;  // the FIFO refuses pushes only when full.
        status.rx_empty = (rx_level_i == '0);
        status.rx_full  = (rx_level_i == fifo_level_t'(FIFO_DEPTH));
        status.busy     = busy_i;
    end

    // a write to TX_DATA is a push, a read of RX_DATA a pop.
    assign tx_data_o  = reg_wdata_i[SPI_DATA_WIDTH-1:0];
    assign tx_valid_o = reg_wr_en_i && (reg_addr_i == REG_TX_DATA);
    assign rx_pop_req = reg_rd_en_i && (reg_addr_i == REG_RX_DATA);
    assign rx_ready_o = rx_pop_req && !status.rx_empty;

    assign cfg_o       = cfg_q;
    assign clear_o     = soft_rst_q;
    assign reg_rdata_o = rdata_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cfg_q      <= CFG_RESET;
            soft_rst_q <= 1'b0;
        end else begin
            soft_rst_q <= 1'b0;
            if (reg_wr_en_i) begin
                case (reg_addr_i)
                    REG_CONTROL: begin
                        soft_rst_q <= wr_ctrl.soft_rst;
                        cfg_q.cpol <= wr_ctrl.cpol;
                        cfg_q.cpha <= wr_ctrl.cpha;
                        cfg_q.stop <= wr_ctrl.stop;
                    end
                    REG_CLK_DIV: cfg_q.clk_div   <= reg_wdata_i[CLK_DIV_WIDTH-1:0];
                    REG_WAIT:    cfg_q.wait_time <= reg_wdata_i[WAIT_WIDTH-1:0];
                    REG_SLAVE:   cfg_q.slave_sel <= reg_wdata_i[$bits(slave_sel_t)-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        rdata_d = '0;
        case (reg_addr_i)
            REG_CONTROL: rdata_d[3:1] = {cfg_q.stop, cfg_q.cpha, cfg_q.cpol};
            REG_STATUS:  rdata_d[$bits(spi_status_t)-1:0] = status;
            REG_CLK_DIV: rdata_d[CLK_DIV_WIDTH-1:0] = cfg_q.clk_div;
            REG_WAIT:    rdata_d[WAIT_WIDTH-1:0] = cfg_q.wait_time;
            REG_SLAVE:   rdata_d[$bits(slave_sel_t)-1:0] = cfg_q.slave_sel;
            REG_RX_DATA: begin
                if (!status.rx_empty) begin
                    rdata_d[SPI_DATA_WIDTH-1:0] = rx_data_i;
                end
            end
            REG_PARAM:   rdata_d = param;
            default: ;  // TX_DATA reads back zero.
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rdata_q <= '0;
        end else if (reg_rd_en_i) begin
            rdata_q <= rdata_d;
        end
    end

    // the pop is gated by the level, so the FIFO must agree that data is there.
    a_pop_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rx_ready_o |-> rx_valid_i);

endmodule

//--- design/spi_shift_engine.sv
// spi master shift engine.
// pops bytes from the TX FIFO, shifts them out MSB first in any CPOL/CPHA mode
// and pushes the captured MISO bytes into the RX FIFO.

module spi_shift_engine (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          clear_i,

    input  spi_pkg::spi_cfg_t             cfg_i,

    input  spi_pkg::spi_data_t            tx_data_i,
    input  logic                          tx_valid_i,
    output logic                          tx_ready_o,

    output spi_pkg::spi_data_t            rx_data_o,
    output logic                          rx_valid_o,
    input  logic                          rx_ready_i,

    output logic                          busy_o,

    output logic                          sclk_o,
    output logic                          mosi_o,
    input  logic                          miso_i,
    output logic [spi_pkg::SLAVE_NUM-1:0] cs_n_o
);
    import spi_pkg::*;

    engine_state_t        state_q;
    spi_cfg_t             cfg_q;
    clk_div_t             div_cnt;
    wait_t                gap_cnt;
    logic [3:0]           edge_cnt;
    spi_data_t            tx_q;
    spi_data_t            rx_q;
    logic                 sclk_q;
    logic [SLAVE_NUM-1:0] cs_n_q;
    logic [SLAVE_NUM-1:0] cs_sel_n;
    logic                 cfg_load;
    logic                 half_done;
    logic                 gap_done;
    logic                 first_edge;
    logic                 do_sample;
    logic                 do_shift;
    logic                 edge_now;

    // the configuration only follows the registers between bytes.
    assign cfg_load  = (state_q == IDLE) || (state_q == GAP);
    assign half_done = (div_cnt == cfg_q.clk_div);
    assign gap_done  = (cfg_q.wait_time == '0) || (gap_cnt == cfg_q.wait_time - 1'b1);

    // even edge_cnt values are the first edge of a bit pair.
    assign first_edge = ~edge_cnt[0];
    assign do_sample  = first_edge ^ cfg_q.cpha;
    assign do_shift   = cfg_q.cpha ? (first_edge && edge_cnt != 4'd0) : ~first_edge;
    assign edge_now   = (state_q == SHIFT) && half_done;

    assign cs_sel_n = ~(SLAVE_NUM'(1) << cfg_i.slave_sel);

    assign tx_ready_o = (state_q == IDLE) || (state_q == GAP && gap_done && !cfg_q.stop);
    assign rx_valid_o = (state_q == TRAIL) && half_done;
    assign rx_data_o  = rx_q;
    assign busy_o     = (state_q != IDLE);
    assign mosi_o     = busy_o & tx_q[7];
    assign sclk_o     = sclk_q;
    assign cs_n_o     = cs_n_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= IDLE;
            cfg_q    <= CFG_RESET;
            sclk_q   <= CFG_RESET.cpol;
            cs_n_q   <= '1;
            div_cnt  <= '0;
            gap_cnt  <= '0;
            edge_cnt <= '0;
        end else if (clear_i) begin
            state_q  <= IDLE;
            cfg_q    <= cfg_i;
            sclk_q   <= cfg_i.cpol;
            cs_n_q   <= '1;
            div_cnt  <= '0;
            gap_cnt  <= '0;
            edge_cnt <= '0;
        end else begin
            if (cfg_load) begin
                cfg_q  <= cfg_i;
                sclk_q <= cfg_i.cpol;
            end
            case (state_q)
                IDLE: begin
                    if (tx_valid_i) begin
                        state_q <= LEAD;
                        div_cnt <= '0;
                        cs_n_q  <= cs_sel_n;
                    end
                end
                LEAD: begin
                    if (half_done) begin
                        state_q  <= SHIFT;
                        div_cnt  <= '0;
                        edge_cnt <= '0;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                SHIFT: begin
                    if (half_done) begin
                        div_cnt  <= '0;
                        sclk_q   <= ~sclk_q;
                        edge_cnt <= edge_cnt + 1'b1;
                        if (edge_cnt == 4'd15) begin
                            state_q <= TRAIL;  // sixteenth edge brings sclk back to idle.
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                TRAIL: begin
                    if (!half_done) begin
                        div_cnt <= div_cnt + 1'b1;
                    end else if (rx_ready_i) begin
                        state_q <= GAP;
                        gap_cnt <= '0;
                    end
                end
                GAP: begin
                    if (!gap_done) begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end else if (tx_valid_i && !cfg_q.stop) begin
                        state_q <= LEAD;
                        div_cnt <= '0;
                        cs_n_q  <= cs_sel_n;
                    end else begin
                        state_q <= IDLE;
                        cs_n_q  <= '1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (tx_ready_o && tx_valid_i) begin
            tx_q <= tx_data_i;
        end else if (edge_now && do_shift) begin
            tx_q <= {tx_q[6:0], 1'b0};
        end
        if (edge_now && do_sample) begin
            rx_q <= {rx_q[6:0], miso_i};
        end
    end

    // no chip select is active while the engine is idle.
    a_one_cs: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(~cs_n_o) && (busy_o || (&cs_n_o)));

    // sclk rests at the polarity in use outside the shift phase, so in IDLE too.
    a_idle_sclk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_q != SHIFT) |-> (sclk_o == cfg_q.cpol));

endmodule

//--- design/spi_fifo.sv
// synchronous byte FIFO with valid/ready on both sides.
// reports its occupancy for the status register.

module spi_fifo #(
    parameter int DEPTH = spi_pkg::FIFO_DEPTH
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 clear_i,

    input  spi_pkg::spi_data_t   in_data_i,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,

    output spi_pkg::spi_data_t   out_data_o,
    output logic                 out_valid_o,
    input  logic                 out_ready_i,

    output spi_pkg::fifo_level_t level_o
);
    import spi_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    spi_data_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    fifo_level_t      level_q;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in_ready_o  = (level_q != fifo_level_t'(DEPTH));
    assign out_valid_o = (level_q != '0);
    assign out_data_o  = mem[rd_ptr];  // head word, shown the cycle after its push.
    assign level_o     = level_q;

    assign push = in_valid_i & in_ready_o;
    assign pop  = out_valid_o & out_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= in_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            level_q <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;  // both or neither leave the count alone.
            endcase
        end
    end

    a_level_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        level_q <= fifo_level_t'(DEPTH));

    a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

//--- design/spi_pkg.sv
// spi master controller package.
// holds the register map, the data widths and the types shared by all blocks.

package spi_pkg;

    localparam int SPI_DATA_WIDTH = 8;
    localparam int REG_DATA_WIDTH = 32;
    localparam int REG_ADDR_WIDTH = 3;
    localparam int REG_NUM        = 8;
    localparam int CLK_DIV_WIDTH  = 8;
    localparam int WAIT_WIDTH     = 8;
    localparam int SLAVE_NUM      = 2;
    localparam int FIFO_DEPTH     = 16;

    typedef logic [SPI_DATA_WIDTH-1:0]      spi_data_t;
    typedef logic [REG_DATA_WIDTH-1:0]      reg_data_t;
    typedef logic [REG_ADDR_WIDTH-1:0]      reg_addr_t;
    typedef logic [CLK_DIV_WIDTH-1:0]       clk_div_t;   // half period in clocks, minus one.
    typedef logic [WAIT_WIDTH-1:0]          wait_t;
    typedef logic [$clog2(SLAVE_NUM)-1:0]   slave_sel_t;
    typedef logic [$clog2(FIFO_DEPTH):0]    fifo_level_t;

    localparam reg_addr_t REG_CONTROL = 3'd0;
    localparam reg_addr_t REG_STATUS  = 3'd1;
    localparam reg_addr_t REG_CLK_DIV = 3'd2;
    localparam reg_addr_t REG_WAIT    = 3'd3;
    localparam reg_addr_t REG_SLAVE   = 3'd4;
    localparam reg_addr_t REG_TX_DATA = 3'd5;
    localparam reg_addr_t REG_RX_DATA = 3'd6;
    localparam reg_addr_t REG_PARAM   = 3'd7;

    // layout of a write to the control register.
    typedef struct packed {
        logic [REG_DATA_WIDTH-5:0] rsvd;
        logic                      stop;
        logic                      cpha;
        logic                      cpol;
        logic                      soft_rst;
    } ctrl_reg_t;

    typedef struct packed {
        logic       cpol;
        logic       cpha;
        logic       stop;
        clk_div_t   clk_div;
        wait_t      wait_time;
        slave_sel_t slave_sel;
    } spi_cfg_t;

    localparam spi_cfg_t CFG_RESET = '{
        cpol:      1'b0,
        cpha:      1'b0,
        stop:      1'b0,
        clk_div:   8'd3,
        wait_time: 8'd2,
        slave_sel: '0
    };

    // tx_empty lands in bit 0 of the status register, busy in bit 4.
    typedef struct packed {
        logic busy;
        logic rx_full;
        logic rx_empty;
        logic tx_full;
        logic tx_empty;
    } spi_status_t;

    typedef struct packed {
        logic [7:0]  reg_num;
        logic [15:0] fifo_depth;
        logic [7:0]  data_width;
    } param_reg_t;

    typedef enum logic [2:0] {
        IDLE,
        LEAD,
        SHIFT,
        TRAIL,
        GAP
    } engine_state_t;

endpackage
